// ==== common/edge_job_pkg.sv ====
package edge_job_pkg;

	////////////////////////////////////////
	// Geometry of edges and cache lines
	////////////////////////////////////////

	localparam int ADDR_W          = 32;
	localparam int EDGE_BYTES      = 4;
	localparam int LINE_BYTES      = 32;
	localparam int LINE_EDGES      = LINE_BYTES / EDGE_BYTES;
	localparam int LINE_W          = LINE_BYTES * 8;
	localparam int EDGE_FIFO_DEPTH = 16;

	// Occupancy counter of the edge queue, 0 to depth
	localparam int QUEUE_LEVEL_W = $clog2(EDGE_FIFO_DEPTH + 1);

	////////////////////////////////////////
	// Vector types
	////////////////////////////////////////

	typedef logic [ADDR_W-1:0]                 addr_t;
	typedef logic [31:0]                       vertex_id_t;
	typedef logic [15:0]                       edge_count_t;
	typedef logic [EDGE_BYTES*8-1:0]           edge_word_t;
	// Slot k sits in bytes 4k..4k+3, byte 0 is the LSB
	typedef logic [LINE_W-1:0]                 line_t;
	typedef logic [$clog2(LINE_EDGES)-1:0]     line_slot_t;
	typedef logic [$clog2(LINE_EDGES+1)-1:0]   line_count_t;

	// One queued edge job as stored in the FIFO
	localparam int EDGE_JOB_W = $bits(vertex_id_t) + $bits(edge_count_t) + $bits(edge_word_t);

	typedef logic [EDGE_JOB_W-1:0] edge_job_t;

	// Fetch sequencer states
	typedef enum logic [1:0] {
		FETCH_WAIT_VERTEX,
		FETCH_PLAN,
		FETCH_ISSUE,
		FETCH_WAIT_DATA
	} fetch_state_t;

endpackage

// ==== common/edge_unpack_if.sv ====
`timescale 1ns/1ns

// Line description handed from the sequencer to the unpacker
interface edge_unpack_if import edge_job_pkg::*; ();

	line_slot_t  seek;
	line_count_t count;
	vertex_id_t  src;
	edge_count_t base_id;
	// Pulses with the last edge push of the line
	logic        done;

	modport sequencer (
		output seek,
		output count,
		output src,
		output base_id,
		input  done
	);

	modport unpacker (
		input  seek,
		input  count,
		input  src,
		input  base_id,
		output done
	);

endinterface

// ==== rtl/sync_fifo.sv ====
`timescale 1ns/1ns

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16
) (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       push,
	input  logic [WIDTH-1:0]           push_data,
	input  logic                       pop,
	output logic [WIDTH-1:0]           pop_data,
	output logic                       pop_valid,
	output logic                       empty,
	output logic [$clog2(DEPTH+1)-1:0] level
);

	logic [WIDTH-1:0]         mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic                     full;
	logic                     do_push;
	logic                     do_pop;

	assign empty   = (level == '0);
	assign full    = (level == DEPTH);
	assign do_push = push && !full;
	// Pop on empty is dropped
	assign do_pop  = pop && !empty;

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
		if (do_pop) begin
			pop_data <= mem[rd_ptr];
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			level     <= '0;
			pop_valid <= 1'b0;
		end else begin
			pop_valid <= do_pop;
			if (do_push) begin
				wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end

endmodule

// ==== edge_fetch/edge_fetch_fsm.sv ====
`timescale 1ns/1ns

module edge_fetch_fsm import edge_job_pkg::*; (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     vertex_valid,
	input  vertex_id_t               vertex_id,
	input  edge_count_t              vertex_edge_idx,
	input  edge_count_t              vertex_degree,
	output logic                     vertex_ready,
	input  addr_t                    edge_base,
	input  logic [QUEUE_LEVEL_W-1:0] queue_level,
	output logic                     read_cmd_request,
	output addr_t                    read_cmd_addr,
	output line_count_t              read_cmd_count,
	input  logic                     read_cmd_grant,
	edge_unpack_if.sequencer         unpack
);

	fetch_state_t state;
	fetch_state_t next_state;

	// Current vertex bookkeeping
	vertex_id_t  cur_src;
	edge_count_t next_idx;
	edge_count_t remaining;
	edge_count_t id_base;

	// Planned command for the line holding next_idx
	addr_t       edge_addr;
	line_slot_t  plan_slot;
	line_count_t plan_room;
	line_count_t plan_count;
	logic        queue_room;

	////////////////////////////////////////
	// Line planning
	////////////////////////////////////////

	always_comb begin
		edge_addr  = edge_base + (addr_t'(next_idx) << $clog2(EDGE_BYTES));
		// Word index inside the line gives the first wanted slot
		plan_slot  = line_slot_t'(edge_addr >> $clog2(EDGE_BYTES));
		plan_room  = line_count_t'(LINE_EDGES) - line_count_t'(plan_slot);
		if (remaining < edge_count_t'(plan_room)) begin
			plan_count = line_count_t'(remaining);
		end else begin
			plan_count = plan_room;
		end
	end

	// Only start a line when the queue can absorb all of it
	assign queue_room = (queue_level <= QUEUE_LEVEL_W'(EDGE_FIFO_DEPTH - LINE_EDGES));

	assign vertex_ready = (state == FETCH_WAIT_VERTEX);

	////////////////////////////////////////
	// State machine
	////////////////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			FETCH_WAIT_VERTEX: begin
				if (vertex_valid) begin
					next_state = FETCH_PLAN;
				end
			end
			FETCH_PLAN: begin
				if (remaining == '0) begin
					next_state = FETCH_WAIT_VERTEX;
				end else if (queue_room) begin
					next_state = FETCH_ISSUE;
				end
			end
			FETCH_ISSUE: begin
				if (read_cmd_grant) begin
					next_state = FETCH_WAIT_DATA;
				end
			end
			FETCH_WAIT_DATA: begin
				if (unpack.done) begin
					next_state = FETCH_PLAN;
				end
			end
			default: next_state = FETCH_WAIT_VERTEX;
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state            <= FETCH_WAIT_VERTEX;
			read_cmd_request <= 1'b0;
			next_idx         <= '0;
			remaining        <= '0;
			id_base          <= '0;
		end else begin
			state <= next_state;
			if (state == FETCH_WAIT_VERTEX && vertex_valid) begin
				next_idx  <= vertex_edge_idx;
				remaining <= vertex_degree;
				id_base   <= '0;
			end
			if (state == FETCH_PLAN && remaining != '0 && queue_room) begin
				read_cmd_request <= 1'b1;
			end
			// Command consumed, move past the edges of this line
			if (state == FETCH_ISSUE && read_cmd_grant) begin
				read_cmd_request <= 1'b0;
				next_idx         <= next_idx + edge_count_t'(read_cmd_count);
				remaining        <= remaining - edge_count_t'(read_cmd_count);
				id_base          <= id_base + edge_count_t'(read_cmd_count);
			end
		end
	end

	// Command and line description, held until the unpacker is done
	always_ff @(posedge clock) begin
		if (state == FETCH_WAIT_VERTEX && vertex_valid) begin
			cur_src <= vertex_id;
		end
		if (state == FETCH_PLAN) begin
			read_cmd_addr  <= edge_addr & ~addr_t'(LINE_BYTES - 1);
			read_cmd_count <= plan_count;
			unpack.seek    <= plan_slot;
			unpack.base_id <= id_base;
		end
	end

	assign unpack.count = read_cmd_count;
	assign unpack.src   = cur_src;

endmodule

// ==== edge_fetch/edge_line_unpacker.sv ====
`timescale 1ns/1ns

module edge_line_unpacker import edge_job_pkg::*; (
	input  logic            clock,
	input  logic            rstn,
	input  logic            read_data_valid,
	input  line_t           read_data,
	edge_unpack_if.unpacker unpack,
	output logic            push,
	output vertex_id_t      push_src,
	output edge_count_t     push_id,
	output edge_word_t      push_dest
);

	line_t       line_q;
	logic        active;
	line_slot_t  slot;
	line_count_t step;
	edge_word_t  slot_word;
	logic        last_step;

	// Edge words are stored big endian in memory
	function automatic edge_word_t swap_bytes(input edge_word_t word);
		edge_word_t swapped;
		for (int b = 0; b < EDGE_BYTES; b++) begin
			swapped[8*b +: 8] = word[8*(EDGE_BYTES-1-b) +: 8];
		end
		return swapped;
	endfunction

	////////////////////////////////////////
	// Line capture and slot walk
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (read_data_valid) begin
			line_q <= read_data;
		end
	end

	assign last_step = (line_count_t'(step + 1'b1) == unpack.count);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			active <= 1'b0;
			slot   <= '0;
			step   <= '0;
		end else if (read_data_valid) begin
			// Leading edges of other vertices are skipped by seeking
			active <= 1'b1;
			slot   <= unpack.seek;
			step   <= '0;
		end else if (active) begin
			slot <= slot + 1'b1;
			step <= step + 1'b1;
			if (last_step) begin
				active <= 1'b0;
			end
		end
	end

	////////////////////////////////////////
	// Edge push toward the queue
	////////////////////////////////////////

	assign slot_word   = line_q[slot * $bits(edge_word_t) +: $bits(edge_word_t)];

	assign push        = active;
	assign push_src    = unpack.src;
	assign push_id     = unpack.base_id + edge_count_t'(step);
	assign push_dest   = swap_bytes(slot_word);
	assign unpack.done = active && last_step;

endmodule

// ==== rtl/edge_job_control.sv ====
`timescale 1ns/1ns

module edge_job_control import edge_job_pkg::*; (
	input  logic        clock,
	input  logic        rstn,
	input  logic        vertex_valid,
	input  vertex_id_t  vertex_id,
	input  edge_count_t vertex_edge_idx,
	input  edge_count_t vertex_degree,
	output logic        vertex_ready,
	input  addr_t       edge_base,
	output logic        read_cmd_request,
	output addr_t       read_cmd_addr,
	output line_count_t read_cmd_count,
	input  logic        read_cmd_grant,
	input  logic        read_data_valid,
	input  line_t       read_data,
	input  logic        edge_request,
	output logic        edge_valid,
	output vertex_id_t  edge_src,
	output edge_word_t  edge_dest,
	output edge_count_t edge_id
);

	edge_unpack_if unpack ();

	logic                     push;
	vertex_id_t               push_src;
	edge_count_t              push_id;
	edge_word_t               push_dest;
	edge_job_t                push_word;
	edge_job_t                pop_word;
	logic [QUEUE_LEVEL_W-1:0] queue_level;

	edge_fetch_fsm i_fetch (
		.clock            (clock),
		.rstn             (rstn),
		.vertex_valid     (vertex_valid),
		.vertex_id        (vertex_id),
		.vertex_edge_idx  (vertex_edge_idx),
		.vertex_degree    (vertex_degree),
		.vertex_ready     (vertex_ready),
		.edge_base        (edge_base),
		.queue_level      (queue_level),
		.read_cmd_request (read_cmd_request),
		.read_cmd_addr    (read_cmd_addr),
		.read_cmd_count   (read_cmd_count),
		.read_cmd_grant   (read_cmd_grant),
		.unpack           (unpack.sequencer)
	);

	edge_line_unpacker i_unpacker (
		.clock           (clock),
		.rstn            (rstn),
		.read_data_valid (read_data_valid),
		.read_data       (read_data),
		.unpack          (unpack.unpacker),
		.push            (push),
		.push_src        (push_src),
		.push_id         (push_id),
		.push_dest       (push_dest)
	);

	// Edge job word layout is src, id, dest from the top
	assign push_word = {push_src, push_id, push_dest};

	sync_fifo #(
		.WIDTH ($bits(edge_job_t)),
		.DEPTH (EDGE_FIFO_DEPTH)
	) i_edge_queue (
		.clock     (clock),
		.rstn      (rstn),
		.push      (push),
		.push_data (push_word),
		.pop       (edge_request),
		.pop_data  (pop_word),
		.pop_valid (edge_valid),
		.empty     (),
		.level     (queue_level)
	);

	assign {edge_src, edge_id, edge_dest} = pop_word;

endmodule

// ==== bench/edge_job_control_sva.sv ====
`timescale 1ns/1ns

module edge_job_control_sva import edge_job_pkg::*; (
	input logic        clock,
	input logic        rstn,
	input logic        read_cmd_request,
	input addr_t       read_cmd_addr,
	input line_count_t read_cmd_count,
	input logic        read_cmd_grant,
	input logic        edge_request,
	input logic        edge_valid
);

	// Read back by the testbench at the end of the run
	int unsigned failures = 0;

	// Ungranted command stays on the port unchanged
	assert property (@(posedge clock) disable iff (!rstn)
		read_cmd_request && !read_cmd_grant |=>
		read_cmd_request && $stable(read_cmd_addr) && $stable(read_cmd_count))
	else begin
		failures++;
		$error("read command changed or dropped before grant");
	end

	assert property (@(posedge clock) disable iff (!rstn)
		edge_valid |-> $past(edge_request))
	else begin
		failures++;
		$error("edge_valid without edge_request in the cycle before");
	end

	assert property (@(posedge clock) disable iff (!rstn)
		read_cmd_request |-> read_cmd_count >= 1 && read_cmd_count <= LINE_EDGES)
	else begin
		failures++;
		$error("read_cmd_count out of range");
	end

	assert property (@(posedge clock) disable iff (!rstn)
		read_cmd_request |-> (read_cmd_addr & addr_t'(LINE_BYTES - 1)) == '0)
	else begin
		failures++;
		$error("read_cmd_addr not line aligned");
	end

endmodule

bind edge_job_control edge_job_control_sva i_sva (.*);

// ==== bench/edge_job_control_tb.sv ====
`timescale 1ns/1ns

module edge_job_control_tb import edge_job_pkg::*; ();

	localparam addr_t       EDGE_BASE      = 32'h0000_4000;
	localparam logic [31:0] SEED           = 32'h048e_4345;
	localparam logic [31:0] LFSR_POLY      = 32'h8020_0003;
	localparam int          NUM_VERTICES   = 35;
	localparam int          TIMEOUT_CYCLES = 300 * NUM_VERTICES;

	typedef struct packed {
		vertex_id_t  src;
		edge_count_t id;
		edge_word_t  dest;
	} expected_edge_t;

	logic        clock;
	logic        rstn;
	logic        vertex_valid;
	vertex_id_t  vertex_id;
	edge_count_t vertex_edge_idx;
	edge_count_t vertex_degree;
	logic        vertex_ready;
	addr_t       edge_base;
	logic        read_cmd_request;
	addr_t       read_cmd_addr;
	line_count_t read_cmd_count;
	logic        read_cmd_grant;
	logic        read_data_valid;
	line_t       read_data;
	logic        edge_request;
	logic        edge_valid;
	vertex_id_t  edge_src;
	edge_word_t  edge_dest;
	edge_count_t edge_id;

	edge_word_t     mem [256];
	expected_edge_t exp_q [$];
	addr_t          cmd_addr_q [$];
	line_count_t    cmd_cnt_q [$];
	logic [31:0]    stim_lfsr = SEED;
	logic [31:0]    bus_lfsr  = SEED;
	logic [31:0]    req_lfsr  = SEED;
	// 0 always request, 1 hold low, 2 random
	int             req_mode  = 0;
	int             errors    = 0;
	int             checks    = 0;
	int             tests_run = 0;
	int             test_base = 0;
	int             line_counts [3] = '{3, 8, 1};

	edge_job_control i_dut (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	////////////////////////////////////////
	// Helpers and reference model
	////////////////////////////////////////

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] rand_bits(inout logic [31:0] state, input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[30:0], state[0]};
			state = (state >> 1) ^ (state[0] ? LFSR_POLY : 32'h0);
		end
		return value;
	endfunction

	function automatic edge_word_t reverse_bytes(input edge_word_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	// Expected jobs of one vertex in output order
	function automatic void build_expected(input vertex_id_t vid, input int idx, input int deg);
		expected_edge_t e;
		for (int k = 0; k < deg; k++) begin
			e.src  = vid;
			e.id   = edge_count_t'(k);
			e.dest = reverse_bytes(mem[(idx + k) % 256]);
			exp_q.push_back(e);
		end
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		checks++;
		assert (got === expected) else begin
			$display("[ERROR] %s: expected %h, got %h", name, expected, got);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		$display("%s: %s, %0d errors", name, (errors == test_base) ? "ok" : "FAILED",
			errors - test_base);
		test_base = errors;
		tests_run++;
	endtask

	task automatic send_vertex(input vertex_id_t vid, input int idx, input int deg);
		logic taken;
		@(posedge clock);
		#2;
		vertex_valid    = 1'b1;
		vertex_id       = vid;
		vertex_edge_idx = edge_count_t'(idx);
		vertex_degree   = edge_count_t'(deg);
		do begin
			@(negedge clock);
			taken = vertex_ready;
			@(posedge clock);
			#2;
		end while (!taken);
		vertex_valid = 1'b0;
		build_expected(vid, idx, deg);
	endtask

	// Wait for all jobs out and the sequencer idle
	task automatic drain();
		do @(negedge clock); while (exp_q.size() != 0 || !vertex_ready);
	endtask

	task automatic clear_log();
		cmd_addr_q.delete();
		cmd_cnt_q.delete();
	endtask

	////////////////////////////////////////
	// Bus model and consumer
	////////////////////////////////////////

	initial begin
		logic [31:0] r;
		int          wbase;
		line_t       data_line;
		forever begin
			@(negedge clock);
			if (rstn && read_cmd_request) begin
				r = rand_bits(bus_lfsr, 2);
				repeat (r + 1) @(posedge clock);
				#2 read_cmd_grant = 1'b1;
				cmd_addr_q.push_back(read_cmd_addr);
				cmd_cnt_q.push_back(read_cmd_count);
				wbase = int'((read_cmd_addr - edge_base) >> 2);
				@(posedge clock);
				#2 read_cmd_grant = 1'b0;
				r = rand_bits(bus_lfsr, 2);
				for (int d = 0; d < r; d++) begin
					@(posedge clock);
					#2;
				end
				for (int k = 0; k < LINE_EDGES; k++) begin
					data_line[32*k +: 32] = mem[(wbase + k) % 256];
				end
				read_data       = data_line;
				read_data_valid = 1'b1;
				@(posedge clock);
				#2 read_data_valid = 1'b0;
			end
		end
	end

	initial begin
		logic [31:0] r;
		forever begin
			@(posedge clock);
			#2;
			case (req_mode)
				0: edge_request = 1'b1;
				1: edge_request = 1'b0;
				default: begin
					r            = rand_bits(req_lfsr, 1);
					edge_request = r[0];
				end
			endcase
		end
	end

	// Compare each popped job with the reference
	initial begin
		expected_edge_t e;
		forever begin
			@(negedge clock);
			if (rstn && edge_valid) begin
				checks++;
				assert (exp_q.size() != 0) else begin
					$display("An edge job came out when none was expected");
					errors++;
				end
				if (exp_q.size() != 0) begin
					e = exp_q.pop_front();
					check_value("edge_src", edge_src, e.src);
					check_value("edge_id", edge_id, e.id);
					check_value("edge_dest", edge_dest, e.dest);
				end
			end
		end
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clock);
		$display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
		$display("test failed");
		$finish;
	end

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		vertex_id_t vid;
		int         idx;
		int         deg;
		rstn            = 1'b0;
		vertex_valid    = 1'b0;
		vertex_id       = '0;
		vertex_edge_idx = '0;
		vertex_degree   = '0;
		edge_base       = EDGE_BASE;
		read_cmd_grant  = 1'b0;
		read_data_valid = 1'b0;
		read_data       = '0;
		edge_request    = 1'b0;
		for (int i = 0; i < 256; i++) begin
			mem[i] = rand_bits(stim_lfsr, 32);
		end
		repeat (2) @(posedge clock);
		#2 rstn = 1'b1;

		@(negedge clock);
		check_value("read_cmd_request", read_cmd_request, 0);
		check_value("edge_valid", edge_valid, 0);
		check_value("vertex_ready", vertex_ready, 1);
		end_test("reset");

		clear_log();
		send_vertex(32'h0000_0a11, 8, 8);
		drain();
		check_value("command count", cmd_cnt_q.size(), 1);
		check_value("read_cmd_addr", cmd_addr_q[0], EDGE_BASE + 32);
		check_value("read_cmd_count", cmd_cnt_q[0], 8);
		end_test("aligned vertex");

		clear_log();
		send_vertex(32'h0000_0b22, 5, 12);
		drain();
		check_value("command count", cmd_cnt_q.size(), 3);
		for (int i = 0; i < 3; i++) begin
			check_value("read_cmd_addr", cmd_addr_q[i], EDGE_BASE + 32 * i);
			check_value("read_cmd_count", cmd_cnt_q[i], line_counts[i]);
		end
		end_test("misaligned vertex");

		clear_log();
		send_vertex(32'h0000_0c33, 40, 0);
		drain();
		check_value("command count", cmd_cnt_q.size(), 0);
		send_vertex(32'h0000_0c34, 20, 5);
		drain();
		check_value("command count", cmd_cnt_q.size(), 2);
		end_test("degree zero vertex");

		// Consumer stalls, queue fills after two lines
		clear_log();
		req_mode = 1;
		send_vertex(32'h0000_0d44, 64, 40);
		repeat (60) @(negedge clock);
		for (int i = 0; i < 20; i++) begin
			@(negedge clock);
			check_value("read_cmd_request", read_cmd_request, 0);
		end
		check_value("command count", cmd_cnt_q.size(), 2);
		req_mode = 0;
		drain();
		check_value("command count", cmd_cnt_q.size(), 5);
		end_test("back-pressure");

		req_mode = 2;
		for (int v = 0; v < 30; v++) begin
			vid = rand_bits(stim_lfsr, 32);
			deg = int'(rand_bits(stim_lfsr, 5));
			idx = int'(rand_bits(stim_lfsr, 8));
			if (idx + deg > 256) begin
				idx = 256 - deg;
			end
			send_vertex(vid, idx, deg);
		end
		drain();
		end_test("random stream");

		errors += i_dut.i_sva.failures;
		$display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// ==== edge_job_control.f ====
common/edge_job_pkg.sv
common/edge_unpack_if.sv
rtl/sync_fifo.sv
edge_fetch/edge_fetch_fsm.sv
edge_fetch/edge_line_unpacker.sv
rtl/edge_job_control.sv
bench/edge_job_control_sva.sv
bench/edge_job_control_tb.sv
